//--- bridge_pkg.sv
`default_nettype none

package bridge_pkg;

   // ****************************************
   // Bus widths
   // ****************************************
   localparam int addr_w = 32;
   localparam int data_w = 64;
   localparam int strb_w = 8;
   localparam int id_w   = 4;

   // AXI response codes
   localparam logic [1:0] resp_okay   = 2'b00;
   localparam logic [1:0] resp_slverr = 2'b10;

   // AHB transfer types, only IDLE and NONSEQ are used
   localparam logic [1:0] htrans_idle   = 2'b00;
   localparam logic [1:0] htrans_nonseq = 2'b10;

   // ****************************************
   // AXI channels
   // ****************************************
   typedef struct packed {
      logic [id_w-1:0]   id;
      logic [addr_w-1:0] addr;
   } axi_aw_t;

   typedef struct packed {
      logic [data_w-1:0] data;
      logic [strb_w-1:0] strb;
   } axi_w_t;

   typedef struct packed {
      logic [id_w-1:0]   id;
      logic [addr_w-1:0] addr;
      logic [2:0]        size;
   } axi_ar_t;

   typedef struct packed {
      logic [id_w-1:0] id;
      logic [1:0]      resp;
   } axi_b_t;

   typedef struct packed {
      logic [id_w-1:0]   id;
      logic [data_w-1:0] data;
      logic [1:0]        resp;
   } axi_r_t;

   // ****************************************
   // AHB-Lite manager and subordinate sides
   // ****************************************
   typedef struct packed {
      logic [addr_w-1:0] haddr;
      logic [2:0]        hsize;
      logic [1:0]        htrans;
      logic              hwrite;
      logic [data_w-1:0] hwdata;
   } ahb_req_t;

   typedef struct packed {
      logic [data_w-1:0] hrdata;
      logic              hready;
      logic              hresp;
   } ahb_rsp_t;

   // Decoded command, decode to sequencer
   typedef struct packed {
      logic              write;
      logic [id_w-1:0]   id;
      logic [addr_w-1:0] addr;   // Dword address on writes
      logic [strb_w-1:0] byteen;
      logic              split;  // Write goes out as byte beats
      logic [2:0]        size;
      logic [data_w-1:0] data;
   } bridge_cmd_t;

   // Completed transaction, sequencer to response stage
   typedef struct packed {
      logic              write;
      logic [id_w-1:0]   id;
      logic              error;
      logic [data_w-1:0] rdata;
   } bridge_result_t;

endpackage

`default_nettype wire

//--- axi_cmd_decode.sv
`timescale 1ns/1ps
`default_nettype none

module axi_cmd_decode (
   input  logic                     bus_clk,
   input  logic                     reset,
   input  bridge_pkg::axi_aw_t      aw,
   input  logic                     aw_valid,
   output logic                     aw_ready,
   input  bridge_pkg::axi_w_t       w,
   input  logic                     w_valid,
   output logic                     w_ready,
   input  bridge_pkg::axi_ar_t      ar,
   input  logic                     ar_valid,
   output logic                     ar_ready,
   output bridge_pkg::bridge_cmd_t  cmd,
   output logic                     cmd_valid,
   input  logic                     cmd_ready
);

   logic                  aw_full_q;
   logic                  w_full_q;
   bridge_pkg::axi_aw_t   aw_q;
   bridge_pkg::axi_w_t    w_q;
   logic                  wr_pend;
   logic                  wr_take;
   logic                  wr_split;
   logic [2:0]            wr_size;

   // ****************************************
   // Write buffer slots
   // ****************************************
   assign aw_ready = aw_valid & ~aw_full_q;    // Low until a request arrives
   assign w_ready  = w_valid & ~w_full_q;
   assign wr_pend  = aw_full_q & w_full_q;
   assign wr_take  = wr_pend & cmd_ready;

   always_ff @(posedge bus_clk) begin
      if (reset) begin
         aw_full_q <= 1'b0;
         w_full_q  <= 1'b0;
      end else begin
         if (aw_ready) begin
            aw_full_q <= 1'b1;
         end else if (wr_take) begin
            aw_full_q <= 1'b0;
         end
         if (w_ready) begin
            w_full_q <= 1'b1;
         end else if (wr_take) begin
            w_full_q <= 1'b0;
         end
      end
   end

   always_ff @(posedge bus_clk) begin
      if (aw_ready) begin
         aw_q <= aw;
      end
      if (w_ready) begin
         w_q <= w;
      end
   end

   // Strobe classification
   always_comb begin
      wr_size  = 3'd0;
      wr_split = 1'b0;
      case (w_q.strb)
         8'hff:                       wr_size = 3'd3;
         8'h0f, 8'hf0:                wr_size = 3'd2;
         8'h03, 8'h0c, 8'h30, 8'hc0:  wr_size = 3'd1;
         8'h01, 8'h02, 8'h04, 8'h08,
         8'h10, 8'h20, 8'h40, 8'h80:  wr_size = 3'd0;
         default: begin
            wr_split = 1'b1;          // One byte beat per set lane
         end
      endcase
   end

   // ****************************************
   // Arbitration, writes first
   // ****************************************
   assign cmd_valid = wr_pend | ar_valid;
   assign ar_ready  = ar_valid & ~wr_pend & cmd_ready;

   always_comb begin
      cmd.write  = wr_pend;
      cmd.id     = wr_pend ? aw_q.id : ar.id;
      cmd.addr   = wr_pend ? {aw_q.addr[bridge_pkg::addr_w-1:3], 3'b000} : ar.addr;
      cmd.byteen = wr_pend ? w_q.strb : '0;
      cmd.split  = wr_pend & wr_split;
      cmd.size   = wr_pend ? wr_size : ar.size;
      cmd.data   = w_q.data;
   end

endmodule

`default_nettype wire

//--- ahb_beat_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module ahb_beat_sequencer (
   input  logic                        bus_clk,
   input  logic                        reset,
   input  bridge_pkg::bridge_cmd_t     cmd,
   input  logic                        cmd_valid,
   output logic                        cmd_ready,
   output bridge_pkg::ahb_req_t        ahb_req,
   input  bridge_pkg::ahb_rsp_t        ahb_rsp,
   output bridge_pkg::bridge_result_t  res,
   output logic                        res_valid,
   input  logic                        res_ready
);

   typedef enum logic [1:0] {
      st_idle,
      st_addr,
      st_data,
      st_done
   } state_t;

   state_t                             state_q;
   bridge_pkg::bridge_cmd_t            cmd_q;
   logic [2:0]                         byte_ptr_q;   // Current byte lane of a write
   logic [bridge_pkg::strb_w-1:0]      rest_mask;
   logic                               more_beats;
   logic                               cmd_take;
   logic                               addr_done;
   logic                               data_ok;
   logic                               data_err;
   logic [bridge_pkg::addr_w-1:0]      beat_addr;
   logic [bridge_pkg::addr_w-1:0]      beat_addr_q;
   logic [2:0]                         beat_size;
   logic                               err_q;
   logic [bridge_pkg::data_w-1:0]      rdata_q;

   // Lowest set lane of a byte enable
   function automatic logic [2:0] first_set(input logic [bridge_pkg::strb_w-1:0] bits);
      logic [2:0] idx;
      idx = 3'd0;
      for (int j = bridge_pkg::strb_w - 1; j >= 0; j--) begin
         if (bits[j]) begin
            idx = 3'(j);
         end
      end
      return idx;
   endfunction

   // Waits for the response stage to empty
   assign cmd_ready = (state_q == st_idle) & res_ready;
   assign cmd_take  = cmd_valid & cmd_ready;
   assign addr_done = (state_q == st_addr) & ahb_rsp.hready;
   assign data_err  = (state_q == st_data) & ahb_rsp.hresp;   // First error cycle
   assign data_ok   = (state_q == st_data) & ahb_rsp.hready & ~ahb_rsp.hresp;

   // Lanes still to go above the pointer
   assign rest_mask  = cmd_q.byteen & (8'hfe << byte_ptr_q);
   assign more_beats = cmd_q.split & (|rest_mask);

   // ****************************************
   // Beat address and size
   // ****************************************
   always_comb begin
      if (cmd_q.write) begin
         beat_addr = {cmd_q.addr[bridge_pkg::addr_w-1:3], byte_ptr_q};
         beat_size = cmd_q.split ? 3'd0 : cmd_q.size;
      end else begin
         beat_addr = cmd_q.addr;                 // Reads go out as requested
         beat_size = cmd_q.size;
      end
   end

   always_comb begin
      ahb_req.haddr  = beat_addr;
      ahb_req.hsize  = beat_size;
      ahb_req.htrans = (state_q == st_addr) ? bridge_pkg::htrans_nonseq
                                            : bridge_pkg::htrans_idle;
      ahb_req.hwrite = cmd_q.write;
      ahb_req.hwdata = cmd_q.data;              // Lanes already match AXI
   end

   // Control FSM
   always_ff @(posedge bus_clk) begin
      if (reset) begin
         state_q <= st_idle;
         err_q   <= 1'b0;
      end else begin
         case (state_q)
            st_idle: begin
               if (cmd_take) begin
                  state_q <= st_addr;
                  err_q   <= 1'b0;
               end
            end
            st_addr: begin
               if (addr_done) begin
                  state_q <= st_data;
               end
            end
            st_data: begin
               if (data_err) begin
                  state_q <= st_done;          // Remaining beats dropped
                  err_q   <= 1'b1;
               end else if (data_ok) begin
                  state_q <= more_beats ? st_addr : st_done;
               end
            end
            default: begin
               if (res_ready) begin
                  state_q <= st_idle;
               end
            end
         endcase
      end
   end

   // ****************************************
   // Command, pointer and data registers
   // ****************************************
   always_ff @(posedge bus_clk) begin
      if (cmd_take) begin
         cmd_q      <= cmd;
         byte_ptr_q <= first_set(cmd.byteen);
      end else if (data_ok & more_beats) begin
         byte_ptr_q <= first_set(rest_mask);     // Step to next set lane
      end
      if (addr_done) begin
         beat_addr_q <= beat_addr;
      end
      if (data_ok) begin
         rdata_q <= ahb_rsp.hrdata;
      end
   end

   assign res_valid = (state_q == st_done);

   always_comb begin
      res.write = cmd_q.write;
      res.id    = cmd_q.id;
      res.error = err_q;
      res.rdata = err_q ? {2{beat_addr_q}} : rdata_q;   // Failing address on error
   end

endmodule

`default_nettype wire

//--- axi_resp_channel.sv
`timescale 1ns/1ps
`default_nettype none

module axi_resp_channel (
   input  logic                        bus_clk,
   input  logic                        reset,
   input  bridge_pkg::bridge_result_t  res,
   input  logic                        res_valid,
   output logic                        res_ready,
   output bridge_pkg::axi_b_t          b,
   output logic                        b_valid,
   input  logic                        b_ready,
   output bridge_pkg::axi_r_t          r,
   output logic                        r_valid,
   input  logic                        r_ready
);

   logic                        full_q;
   bridge_pkg::bridge_result_t  res_q;
   logic [1:0]                  resp_code;

   assign res_ready = ~full_q;
   assign b_valid   = full_q & res_q.write;
   assign r_valid   = full_q & ~res_q.write;

   always_ff @(posedge bus_clk) begin
      if (reset) begin
         full_q <= 1'b0;
      end else if (res_valid & res_ready) begin
         full_q <= 1'b1;
      end else if ((b_valid & b_ready) | (r_valid & r_ready)) begin
         full_q <= 1'b0;                        // Handshake done
      end
   end

   // Held while the AXI side stalls
   always_ff @(posedge bus_clk) begin
      if (res_valid & res_ready) begin
         res_q <= res;
      end
   end

   assign resp_code = res_q.error ? bridge_pkg::resp_slverr : bridge_pkg::resp_okay;

   always_comb begin
      b.id   = res_q.id;
      b.resp = resp_code;
      r.id   = res_q.id;
      r.data = res_q.rdata;
      r.resp = resp_code;
   end

endmodule

`default_nettype wire

//--- axi4_to_ahb_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module axi4_to_ahb_bridge (
   input  logic                    bus_clk,
   input  logic                    reset,
   input  bridge_pkg::axi_aw_t     aw,
   input  logic                    aw_valid,
   output logic                    aw_ready,
   input  bridge_pkg::axi_w_t      w,
   input  logic                    w_valid,
   output logic                    w_ready,
   input  bridge_pkg::axi_ar_t     ar,
   input  logic                    ar_valid,
   output logic                    ar_ready,
   output bridge_pkg::axi_b_t      b,
   output logic                    b_valid,
   input  logic                    b_ready,
   output bridge_pkg::axi_r_t      r,
   output logic                    r_valid,
   input  logic                    r_ready,
   output bridge_pkg::ahb_req_t    ahb_req,
   input  bridge_pkg::ahb_rsp_t    ahb_rsp
);

   bridge_pkg::bridge_cmd_t     cmd;
   logic                        cmd_valid;
   logic                        cmd_ready;
   bridge_pkg::bridge_result_t  res;
   logic                        res_valid;
   logic                        res_ready;

   // AXI requests into bus commands
   axi_cmd_decode u_decode (
      .bus_clk   (bus_clk),
      .reset     (reset),
      .aw        (aw),
      .aw_valid  (aw_valid),
      .aw_ready  (aw_ready),
      .w         (w),
      .w_valid   (w_valid),
      .w_ready   (w_ready),
      .ar        (ar),
      .ar_valid  (ar_valid),
      .ar_ready  (ar_ready),
      .cmd       (cmd),
      .cmd_valid (cmd_valid),
      .cmd_ready (cmd_ready)
   );

   ahb_beat_sequencer u_seq (
      .bus_clk   (bus_clk),
      .reset     (reset),
      .cmd       (cmd),
      .cmd_valid (cmd_valid),
      .cmd_ready (cmd_ready),
      .ahb_req   (ahb_req),
      .ahb_rsp   (ahb_rsp),
      .res       (res),
      .res_valid (res_valid),
      .res_ready (res_ready)
   );

   // B or R back to the AXI manager
   axi_resp_channel u_resp (
      .bus_clk   (bus_clk),
      .reset     (reset),
      .res       (res),
      .res_valid (res_valid),
      .res_ready (res_ready),
      .b         (b),
      .b_valid   (b_valid),
      .b_ready   (b_ready),
      .r         (r),
      .r_valid   (r_valid),
      .r_ready   (r_ready)
   );

endmodule

`default_nettype wire

//--- tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
   output logic bus_clk,
   output logic reset
);

   // 4 ns period
   initial begin
      bus_clk = 1'b0;
      forever #2 bus_clk = ~bus_clk;
   end

   initial begin
      reset = 1'b1;
      repeat (10) @(posedge bus_clk);
      @(negedge bus_clk);
      reset = 1'b0;                     // Released on a falling edge
   end

endmodule

`default_nettype wire

//--- tb_ahb_memory.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ahb_memory (
   input  logic                  bus_clk,
   input  logic                  reset,
   input  bridge_pkg::ahb_req_t  ahb_req,
   output bridge_pkg::ahb_rsp_t  ahb_rsp
);

   typedef enum logic [1:0] {
      ph_idle,
      ph_data,
      ph_err1,
      ph_err2
   } phase_t;

   phase_t       phase_q;
   logic [1:0]   wait_q;
   logic [31:0]  addr_q;
   logic [2:0]   size_q;
   logic         write_q;
   logic [63:0]  rdata_q;
   logic         accept;
   logic [7:0]   mem [logic [31:0]];       // Sparse byte store

   // Unwritten bytes read back as a mix of the whole address
   function automatic logic [7:0] fill_byte(input logic [31:0] a);
      return a[31:24] ^ a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'ha5;
   endfunction

   function automatic logic [63:0] read_dword(input logic [31:0] a);
      logic [63:0] d;
      logic [31:0] ba;
      for (int i = 0; i < 8; i++) begin
         ba = {a[31:3], 3'(i)};
         d[8*i +: 8] = mem.exists(ba) ? mem[ba] : fill_byte(ba);
      end
      return d;
   endfunction

   always_comb begin
      ahb_rsp.hready = (phase_q == ph_idle) | (phase_q == ph_err2) |
                       ((phase_q == ph_data) & (wait_q == 2'd0));
      ahb_rsp.hresp  = (phase_q == ph_err1) | (phase_q == ph_err2);
      ahb_rsp.hrdata = rdata_q;
   end

   assign accept = ahb_rsp.hready & (ahb_req.htrans == bridge_pkg::htrans_nonseq);

   // ****************************************
   // Address and data phase tracking
   // ****************************************
   always_ff @(posedge bus_clk) begin
      if (reset) begin
         phase_q <= ph_idle;
         wait_q  <= 2'd0;
      end else begin
         case (phase_q)
            ph_data: begin
               if (wait_q != 2'd0) begin
                  wait_q <= wait_q - 2'd1;
               end else begin
                  phase_q <= ph_idle;
               end
            end
            ph_err1: phase_q <= ph_err2;  // Two-cycle error response
            ph_err2: phase_q <= ph_idle;
            default: phase_q <= ph_idle;
         endcase
         if (accept) begin
            addr_q  <= ahb_req.haddr;
            size_q  <= ahb_req.hsize;
            write_q <= ahb_req.hwrite;
            rdata_q <= read_dword(ahb_req.haddr);
            wait_q  <= 2'($urandom_range(0, 3));
            phase_q <= (ahb_req.haddr[31:28] == 4'hf) ? ph_err1 : ph_data;
         end
      end
   end

   // Write lands on the last data phase cycle
   always @(posedge bus_clk) begin
      int lo;
      int hi;
      lo = int'(addr_q[2:0]);
      hi = lo + (1 << size_q);
      if (!reset && phase_q == ph_data && wait_q == 2'd0 && write_q) begin
         for (int i = 0; i < 8; i++) begin
            if (i >= lo && i < hi) begin
               mem[{addr_q[31:3], 3'(i)}] = ahb_req.hwdata[8*i +: 8];
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- tb_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_bridge;

   localparam int num_txn        = 300;
   localparam int timeout_cycles = num_txn * 60;
   localparam int ch_aw          = 0;
   localparam int ch_w           = 1;
   localparam int ch_ar          = 2;

   // One issued transaction, kept until its response is checked
   typedef struct packed {
      logic        write;
      logic [3:0]  id;
      logic [31:0] addr;
      logic [2:0]  size;
      logic [7:0]  strb;
      logic [63:0] data;
   } txn_t;

   logic                     bus_clk;
   logic                     reset;
   bridge_pkg::axi_aw_t      aw;
   logic                     aw_valid;
   logic                     aw_ready;
   bridge_pkg::axi_w_t       w;
   logic                     w_valid;
   logic                     w_ready;
   bridge_pkg::axi_ar_t      ar;
   logic                     ar_valid;
   logic                     ar_ready;
   bridge_pkg::axi_b_t       b;
   logic                     b_valid;
   logic                     b_ready;
   bridge_pkg::axi_r_t       r;
   logic                     r_valid;
   logic                     r_ready;
   bridge_pkg::ahb_req_t     ahb_req;
   bridge_pkg::ahb_rsp_t     ahb_rsp;

   logic [7:0]   model_mem [logic [31:0]];   // Reference byte memory
   logic [35:0]  exp_beats[$];                // {haddr, hsize, hwrite}
   logic [35:0]  seen_beats[$];
   txn_t         pending[$];                  // Issued, response not yet taken
   int           issue_cnt;
   logic         issue_done;
   int           cycle_cnt = 0;

   tb_clock_gen u_clk (
      .bus_clk (bus_clk),
      .reset   (reset)
   );

   axi4_to_ahb_bridge UUT (
      .bus_clk  (bus_clk),
      .reset    (reset),
      .aw       (aw),
      .aw_valid (aw_valid),
      .aw_ready (aw_ready),
      .w        (w),
      .w_valid  (w_valid),
      .w_ready  (w_ready),
      .ar       (ar),
      .ar_valid (ar_valid),
      .ar_ready (ar_ready),
      .b        (b),
      .b_valid  (b_valid),
      .b_ready  (b_ready),
      .r        (r),
      .r_valid  (r_valid),
      .r_ready  (r_ready),
      .ahb_req  (ahb_req),
      .ahb_rsp  (ahb_rsp)
   );

   tb_ahb_memory u_mem (
      .bus_clk (bus_clk),
      .reset   (reset),
      .ahb_req (ahb_req),
      .ahb_rsp (ahb_rsp)
   );

   // ****************************************
   // Error reporting
   // ****************************************
   task automatic report_failure(input string why);
      $display("%s", why);
      $display("Result: FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic report_mismatch(input string test, input logic [63:0] expected,
                                  input logic [63:0] actual);
      report_failure($sformatf("MISMATCH %s expected 0x%0h actual 0x%0h",
                               test, expected, actual));
   endtask

   // ****************************************
   // Reference model
   // ****************************************
   function automatic logic [7:0] expected_fill(input logic [31:0] a);
      return a[31:24] ^ a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'ha5;
   endfunction

   function automatic logic [63:0] model_dword(input logic [31:0] a);
      logic [63:0] d;
      logic [31:0] ba;
      for (int i = 0; i < 8; i++) begin
         ba = {a[31:3], 3'(i)};
         d[8*i +: 8] = model_mem.exists(ba) ? model_mem[ba] : expected_fill(ba);
      end
      return d;
   endfunction

   // One sized beat for an aligned strobe, else byte beats low to high
   function automatic void expect_write_beats(input logic [31:0] base, input logic [7:0] strb,
                                              input logic err);
      int n;
      int lo;
      logic [2:0] sz;
      n  = $countones(strb);
      lo = 0;
      for (int i = 7; i >= 0; i--) begin
         if (strb[i]) lo = i;
      end
      sz = (n == 8) ? 3'd3 : (n == 4) ? 3'd2 : (n == 2) ? 3'd1 : 3'd0;
      if ((n == 1 || n == 2 || n == 4 || n == 8) && (lo % n == 0) &&
          (strb == 8'(((1 << n) - 1) << lo))) begin
         exp_beats.push_back({base | 32'(lo), sz, 1'b1});
      end else begin
         for (int i = 0; i < 8; i++) begin
            if (strb[i] && !(err && exp_beats.size() > 0)) begin  // Stop after a failing beat
               exp_beats.push_back({base | 32'(i), 3'd0, 1'b1});
            end
         end
      end
   endfunction

   function automatic logic [31:0] pick_dword();
      logic [31:0] a;
      a = ($urandom_range(0, 7) == 0) ? 32'hf000_0000 : 32'h0000_4000;  // Error region 1 in 8
      return a | (32'($urandom_range(0, 63)) << 3);
   endfunction

   function automatic logic [7:0] random_strobe();
      int n;
      int lo;
      if ($urandom_range(0, 1) == 0) begin
         return 8'($urandom_range(1, 255));
      end
      n  = 1 << $urandom_range(0, 3);
      lo = n * int'($urandom_range(0, 8 / n - 1));
      return 8'(((1 << n) - 1) << lo);
   endfunction

   function automatic logic ready_of(input int ch);
      return (ch == ch_aw) ? aw_ready : (ch == ch_w) ? w_ready : ar_ready;
   endfunction

   // ****************************************
   // Bus drivers
   // ****************************************
   task automatic hold_until_ready(input int ch);
      #1;
      while (!ready_of(ch)) begin
         @(negedge bus_clk);
         #1;
      end
      @(negedge bus_clk);                    // Transfer took place on the rising edge
   endtask

   task automatic check_beats(input string test);
      assert (seen_beats.size() == exp_beats.size())
         else report_mismatch({test, " count"}, 64'(exp_beats.size()), 64'(seen_beats.size()));
      foreach (exp_beats[i]) begin
         assert (seen_beats[i] == exp_beats[i])
            else report_mismatch(test, 64'(exp_beats[i]), 64'(seen_beats[i]));
      end
      seen_beats.delete();
      exp_beats.delete();
   endtask

   task automatic take_response(input txn_t t);
      bridge_pkg::axi_b_t b_held;
      bridge_pkg::axi_r_t r_held;
      logic        err;
      logic [1:0]  resp;
      logic [63:0] exp_data;
      int          hold;
      err  = (t.addr[31:28] == 4'hf);
      resp = err ? bridge_pkg::resp_slverr : bridge_pkg::resp_okay;
      while (!(t.write ? b_valid : r_valid)) begin
         @(negedge bus_clk);
      end
      // All beats of this transaction are done once its response shows
      if (t.write) begin
         expect_write_beats(t.addr, t.strb, err);
         check_beats("write beats");
      end else begin
         exp_beats.push_back({t.addr, t.size, 1'b0});
         check_beats("read beat");
      end
      b_held = b;
      r_held = r;
      if (t.write) begin
         assert (b_held.id == t.id)
            else report_mismatch("b id", 64'(t.id), 64'(b_held.id));
         assert (b_held.resp == resp)
            else report_mismatch("b resp", 64'(resp), 64'(b_held.resp));
      end else begin
         exp_data = err ? {t.addr, t.addr} : model_dword(t.addr);   // Failing address on error
         assert (r_held.id == t.id)
            else report_mismatch("r id", 64'(t.id), 64'(r_held.id));
         assert (r_held.resp == resp)
            else report_mismatch("r resp", 64'(resp), 64'(r_held.resp));
         assert (r_held.data == exp_data)
            else report_mismatch("read data", exp_data, r_held.data);
      end
      hold = $urandom_range(0, 4);
      repeat (hold) begin
         @(negedge bus_clk);
         assert (t.write ? (b_valid && b == b_held) : (r_valid && r == r_held))
            else report_failure("response dropped or changed while ready was held low");
      end
      if (t.write) b_ready = 1'b1;
      else r_ready = 1'b1;
      @(negedge bus_clk);
      b_ready = 1'b0;
      r_ready = 1'b0;
      if (t.write && !err) begin
         for (int i = 0; i < 8; i++) begin
            if (t.strb[i]) model_mem[t.addr | 32'(i)] = t.data[8*i +: 8];
         end
      end
   endtask

   task automatic issue_write(input logic [31:0] base, input logic [7:0] strb,
                              input logic [63:0] data);
      txn_t t;
      int   d_aw;
      int   d_w;
      t.write = 1'b1;
      t.id    = 4'($urandom);
      t.addr  = base;
      t.size  = 3'd0;
      t.strb  = strb;
      t.data  = data;
      d_aw    = $urandom_range(0, 3);
      d_w     = $urandom_range(0, 3);
      pending.push_back(t);
      issue_cnt++;
      fork
         begin
            repeat (d_aw) @(negedge bus_clk);
            aw.id    = t.id;
            aw.addr  = t.addr;
            aw_valid = 1'b1;
            hold_until_ready(ch_aw);
            aw_valid = 1'b0;
         end
         begin
            repeat (d_w) @(negedge bus_clk);
            w.data  = t.data;
            w.strb  = t.strb;
            w_valid = 1'b1;
            hold_until_ready(ch_w);
            w_valid = 1'b0;
         end
      join
   endtask

   task automatic issue_read(input logic [31:0] addr, input logic [2:0] size);
      txn_t t;
      t.write = 1'b0;
      t.id    = 4'($urandom);
      t.addr  = addr;
      t.size  = size;
      t.strb  = '0;
      t.data  = '0;
      pending.push_back(t);
      issue_cnt++;
      ar.id    = t.id;
      ar.addr  = addr;
      ar.size  = size;
      ar_valid = 1'b1;
      hold_until_ready(ch_ar);
      ar_valid = 1'b0;
   endtask

   // Requests go out while earlier responses may still be held
   task automatic issue_transactions();
      logic [31:0] base;
      logic [2:0]  size;
      logic [2:0]  offset;
      while (issue_cnt < num_txn) begin
         base = pick_dword();
         case ($urandom_range(0, 3))
            0: begin
               issue_write(base, 8'hff, {$urandom, $urandom});   // Full write then readback
               issue_read(base, 3'd3);
            end
            1: issue_write(base, random_strobe(), {$urandom, $urandom});
            default: begin
               size   = 3'($urandom_range(0, 3));
               offset = 3'($urandom_range(0, 7)) & ~((3'd1 << size) - 3'd1);
               issue_read(base | {29'd0, offset}, size);
            end
         endcase
      end
      issue_done = 1'b1;
   endtask

   task automatic collect_responses();
      txn_t t;
      while (!issue_done || pending.size() != 0) begin
         if (pending.size() == 0) begin
            @(negedge bus_clk);
         end else begin
            t = pending.pop_front();
            take_response(t);
         end
      end
   endtask

   task automatic check_idle_outputs(input string phase);
      assert (!aw_ready && !w_ready && !ar_ready && !b_valid && !r_valid)
         else report_failure({phase, ": a valid or ready output is high with no request"});
      assert (ahb_req.htrans == bridge_pkg::htrans_idle)
         else report_mismatch({phase, " htrans"}, 64'(bridge_pkg::htrans_idle),
                              64'(ahb_req.htrans));
   endtask

   // ****************************************
   // AHB monitor and watchdog
   // ****************************************
   always @(negedge bus_clk) begin
      if (!reset && ahb_req.htrans == bridge_pkg::htrans_nonseq && ahb_rsp.hready) begin
         assert ((ahb_req.haddr & ((32'd1 << ahb_req.hsize) - 32'd1)) == 32'd0)
            else report_mismatch("beat alignment", 64'd0,
                                 64'(ahb_req.haddr & ((32'd1 << ahb_req.hsize) - 32'd1)));
         seen_beats.push_back({ahb_req.haddr, ahb_req.hsize, ahb_req.hwrite});
      end
      assert (!((b_valid || r_valid) && ahb_req.htrans == bridge_pkg::htrans_nonseq))
         else report_failure("an AHB transfer started while a response was pending");
   end

   always @(posedge bus_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      assert (cycle_cnt < timeout_cycles)
         else report_failure("timeout: the run hung before all transactions completed");
   end

   initial begin
      void'($urandom(59));
      aw         = '0;
      aw_valid   = 1'b0;
      w          = '0;
      w_valid    = 1'b0;
      ar         = '0;
      ar_valid   = 1'b0;
      b_ready    = 1'b0;
      r_ready    = 1'b0;
      issue_cnt  = 0;
      issue_done = 1'b0;
      @(posedge bus_clk);
      @(negedge bus_clk);
      repeat (9) begin
         check_idle_outputs("during reset");
         @(negedge bus_clk);
      end
      wait (!reset);
      repeat (3) begin
         @(negedge bus_clk);
         check_idle_outputs("after reset");
      end
      fork
         issue_transactions();
         collect_responses();
      join
      $display("Result: PASSED");
      $finish;
   end

endmodule

`default_nettype wire

//--- tb.f
bridge_pkg.sv
axi_cmd_decode.sv
ahb_beat_sequencer.sv
axi_resp_channel.sv
axi4_to_ahb_bridge.sv
tb_clock_gen.sv
tb_ahb_memory.sv
tb_bridge.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
   --top-module tb_bridge \
   -f tb.f \
   -o tb_bridge_sim

./obj_dir/tb_bridge_sim
